// ==== source/coprocessor_cfg.svh ====
`ifndef COPROCESSOR_CFG_SVH
`define COPROCESSOR_CFG_SVH

// width of one string character
`define CHAR_W 8

// log2 of the window slot count
`define CC_ID_BITS 2

// slots in the sliding window
`define WINDOW_CHARS 4

// one memory word holds eight characters
`define MEM_W 64

// log2 of characters per memory word
`define CHAR_ADDR_OFFSET 3

// character pointer width
`define PTR_W 16

// word address is the pointer without its in-word character bits
`define MEM_ADDR_W 13

`endif

// ==== source/window_pkg.sv ====
`include "coprocessor_cfg.svh"

package window_pkg;

    // a single string character
    typedef logic [`CHAR_W-1:0] char_t;

    // character pointer into the string memory
    typedef logic [`PTR_W-1:0] char_ptr_t;

    // word address seen by the memory port
    typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

    // one memory word, character 0 in the low byte
    typedef logic [`MEM_W-1:0] mem_word_t;

    // window data, slot i sits at bits i*CHAR_W
    typedef logic [`WINDOW_CHARS*`CHAR_W-1:0] window_t;

    // one flag bit per window slot
    typedef logic [`WINDOW_CHARS-1:0] slot_flags_t;

    // index of a window slot
    typedef logic [`CC_ID_BITS-1:0] slot_idx_t;

endpackage

// ==== source/supervisor_pkg.sv ====
package supervisor_pkg;

    // supervisor sequencing states
    typedef enum logic [2:0] {
        IDLE,
        FETCH_FIRST,
        FETCH_MEM,
        FETCH_BUFFER,
        EXE,
        DONE_ACCEPT,
        DONE_REJECT,
        ERROR
    } sup_state_t;

    // summary level reported by the engines
    // used for any_accept, any_running and all_full
    typedef logic engine_flags_t;

endpackage

// ==== source/char_buffer.sv ====
`include "coprocessor_cfg.svh"

module char_buffer
(
    input  logic                   clk,
    input  logic                   rst,
    input  window_pkg::char_ptr_t  start_ptr,
    input  window_pkg::char_ptr_t  end_ptr,
    input  window_pkg::mem_word_t  mem_data,
    input  logic                   capture_start,
    input  logic                   load_first,
    input  logic                   shift,
    input  logic                   fill_from_mem,
    input  logic                   fill_from_buffer,
    input  logic                   sel_start_addr,
    output window_pkg::mem_addr_t  mem_addr,
    output window_pkg::window_t    window,
    output logic                   start_misaligned,
    output logic                   fetch_from_mem_due,
    output logic                   at_end_ptr,
    output logic                   end_in_first_window,
    output window_pkg::slot_idx_t  cur_slot,
    output window_pkg::slot_idx_t  end_slot
);
    import window_pkg::*;

    localparam int WINDOW_BITS = `WINDOW_CHARS * `CHAR_W;

    // points at the next character to bring into the window
    char_ptr_t win_ptr;
    // last word read from memory that serves the fills needing no new fetch
    mem_word_t word_buf;
    // source word and character of the current fill
    mem_word_t fill_src;
    char_t     fill_char;

    // start must sit on a window boundary so the first load is one block
    assign start_misaligned    = |start_ptr[`CC_ID_BITS-1:0];
    // pointer crossed into a new word so the buffer has nothing left
    assign fetch_from_mem_due  = win_ptr[`CHAR_ADDR_OFFSET-1:0] == '0;
    assign at_end_ptr          = win_ptr == end_ptr;
    // end falls inside the window loaded at start
    assign end_in_first_window = start_ptr[`PTR_W-1:`CC_ID_BITS] == end_ptr[`PTR_W-1:`CC_ID_BITS];
    assign cur_slot            = win_ptr[`CC_ID_BITS-1:0];
    assign end_slot            = end_ptr[`CC_ID_BITS-1:0];

    // start word while idle, otherwise the word holding the next character
    assign mem_addr = sel_start_addr ? start_ptr[`PTR_W-1:`CHAR_ADDR_OFFSET]
                                     : win_ptr[`PTR_W-1:`CHAR_ADDR_OFFSET];

    // a fill from memory takes the fresh word, a buffer fill the held one
    assign fill_src  = fill_from_mem ? mem_data : word_buf;
    assign fill_char = fill_src[win_ptr[`CHAR_ADDR_OFFSET-1:0]*`CHAR_W +: `CHAR_W];

    // window end pointer
    always_ff @(posedge clk)
    begin
        if (rst)
            win_ptr <= '0;
        else if (capture_start)
            win_ptr <= start_ptr;
        // the whole first window arrives at once
        else if (load_first)
            win_ptr <= win_ptr + char_ptr_t'(`WINDOW_CHARS);
        else if (fill_from_mem || fill_from_buffer)
            win_ptr <= win_ptr + 1'b1;
    end

    // word buffer and window data
    always_ff @(posedge clk)
    begin
        if (load_first || fill_from_mem)
            word_buf <= mem_data;
        if (load_first)
        begin
            // aligned half of the word selected by the pointer
            window <= mem_data[win_ptr[`CHAR_ADDR_OFFSET-1:`CC_ID_BITS]*WINDOW_BITS +: WINDOW_BITS];
        end
        else if (fill_from_mem || fill_from_buffer)
        begin
            window[cur_slot*`CHAR_W +: `CHAR_W] <= fill_char;
        end
    end

    // window has to fit in one memory word
    a_window_fits: assert property (@(posedge clk) WINDOW_BITS <= `MEM_W)
        else $error("window wider than memory word");

    // the window takes at most one load or fill per cycle
    a_one_fill: assert property (@(posedge clk) disable iff (rst)
        $onehot0({load_first, fill_from_mem, fill_from_buffer}))
        else $error("conflicting window fills");

    // every advance is followed by the fill of the freed slot
    a_fill_after_shift: assert property (@(posedge clk) disable iff (rst)
        shift |=> (fill_from_mem || fill_from_buffer))
        else $error("advance without a fill");

endmodule

// ==== source/window_flags.sv ====
`include "coprocessor_cfg.svh"

module window_flags
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load_first,
    input  logic                    shift,
    input  logic                    fill,
    input  logic                    end_in_first_window,
    input  logic                    at_end_ptr,
    input  window_pkg::slot_idx_t   cur_slot,
    input  window_pkg::slot_idx_t   end_slot,
    input  window_pkg::slot_flags_t elaborating_chars,
    output window_pkg::slot_flags_t window_enable,
    output window_pkg::slot_flags_t window_end_of_s,
    output logic                    first_executing,
    output logic                    first_is_end
);
    import window_pkg::*;

    // slot holding the oldest character of the window
    slot_flags_t is_first;
    // slots past the terminator that need no work
    slot_flags_t after_end;
    // end and after-end flags of the first window
    slot_flags_t first_end;
    slot_flags_t first_after_end;
    // after-end flags once the window advances
    slot_flags_t shift_after_end;

    // rotate left by one slot, the oldest slot wraps around
    function automatic slot_flags_t rotl(input slot_flags_t v);
        return {v[`WINDOW_CHARS-2:0], v[`WINDOW_CHARS-1]};
    endfunction

    always_comb
    begin
        first_end = '0;
        if (end_in_first_window)
            first_end[end_slot] = 1'b1;
        // every slot above the end slot is past the end
        for (int i = 0; i < `WINDOW_CHARS; i++)
            first_after_end[i] = end_in_first_window && (i > int'(end_slot));
    end

    // the slot after an end or after-end slot is past the end as well
    assign shift_after_end = after_end | rotl(after_end) | rotl(window_end_of_s);

    // oldest character still under work by some engine
    assign first_executing = |(is_first & elaborating_chars);
    assign first_is_end    = |(is_first & window_end_of_s);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            window_enable   <= '0;
            window_end_of_s <= '0;
            is_first        <= '0;
            after_end       <= '0;
        end
        else if (load_first)
        begin
            // the top slot waits for the first advance
            window_enable   <= {1'b0, {(`WINDOW_CHARS-1){1'b1}}} & ~first_after_end;
            is_first        <= slot_flags_t'(1);
            window_end_of_s <= first_end;
            after_end       <= first_after_end;
        end
        else if (shift)
        begin
            window_enable <= rotl(window_enable) & ~shift_after_end;
            is_first      <= rotl(is_first);
            after_end     <= shift_after_end;
        end
        else if (fill)
        begin
            // the filled slot gets a new character, mark it when it is the terminator
            window_end_of_s[cur_slot] <= at_end_ptr;
        end
    end

    // while any slot is enabled the oldest one is unique
    a_first_onehot: assert property (@(posedge clk) disable iff (rst)
        |window_enable |-> $onehot(is_first))
        else $error("first slot not unique");

endmodule

// ==== source/supervisor_fsm.sv ====
module supervisor_fsm
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          valid,
    input  logic                          mem_ready,
    input  logic                          engine_start_ready,
    input  supervisor_pkg::engine_flags_t any_accept,
    input  supervisor_pkg::engine_flags_t any_running,
    input  supervisor_pkg::engine_flags_t all_full,
    input  logic                          start_misaligned,
    input  logic                          fetch_from_mem_due,
    input  logic                          first_executing,
    input  logic                          first_is_end,
    input  logic                          no_work,
    output logic                          ready,
    output logic                          done,
    output logic                          accept,
    output logic                          error,
    output logic                          mem_valid,
    output logic                          new_char,
    output logic                          engine_start,
    output logic                          engine_rst,
    output logic                          capture_start,
    output logic                          load_first,
    output logic                          shift,
    output logic                          fill_from_mem,
    output logic                          fill_from_buffer,
    output logic                          sel_start_addr
);
    import supervisor_pkg::*;

    sup_state_t state;
    sup_state_t next_state;

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state       = state;
        ready            = 1'b0;
        done             = 1'b0;
        accept           = 1'b0;
        error            = 1'b0;
        mem_valid        = 1'b0;
        new_char         = 1'b0;
        engine_start     = 1'b0;
        // engines are flushed with the controller and after each run
        engine_rst       = rst;
        capture_start    = 1'b0;
        load_first       = 1'b0;
        shift            = 1'b0;
        fill_from_mem    = 1'b0;
        fill_from_buffer = 1'b0;
        sel_start_addr   = 1'b0;
        case (state)
            IDLE:
            begin
                // keep the start word requested so a start can go at once
                sel_start_addr = 1'b1;
                mem_valid      = 1'b1;
                ready          = mem_ready;
                if (valid && mem_ready)
                begin
                    if (start_misaligned)
                    begin
                        next_state = ERROR;
                    end
                    else
                    begin
                        capture_start = 1'b1;
                        next_state    = FETCH_FIRST;
                    end
                end
            end
            FETCH_FIRST:
            begin
                // start word is on mem_data now, engines start at pc zero
                load_first   = 1'b1;
                engine_start = 1'b1;
                next_state   = engine_start_ready ? EXE : ERROR;
            end
            EXE:
            begin
                // accept, then full, then end of work, then advance
                casez ({any_accept, all_full, !first_executing,
                        first_is_end || no_work, fetch_from_mem_due})
                    5'b1????: next_state = DONE_ACCEPT;
                    // a thread would be lost with every engine full
                    5'b01???: next_state = ERROR;
                    5'b0011?: next_state = DONE_REJECT;
                    5'b00101:
                    begin
                        // buffer used up, the next character needs a new word
                        mem_valid = 1'b1;
                        if (mem_ready)
                        begin
                            shift      = 1'b1;
                            new_char   = 1'b1;
                            next_state = FETCH_MEM;
                        end
                    end
                    5'b00100:
                    begin
                        shift      = 1'b1;
                        new_char   = 1'b1;
                        next_state = FETCH_BUFFER;
                    end
                    default: next_state = EXE;
                endcase
            end
            FETCH_MEM, FETCH_BUFFER:
            begin
                fill_from_mem    = state == FETCH_MEM;
                fill_from_buffer = state == FETCH_BUFFER;
                // idle engines with no accept mean no match
                if (any_accept)
                    next_state = DONE_ACCEPT;
                else if (any_running)
                    next_state = EXE;
                else
                    next_state = DONE_REJECT;
            end
            DONE_ACCEPT:
            begin
                done       = 1'b1;
                accept     = 1'b1;
                engine_rst = 1'b1;
                next_state = IDLE;
            end
            DONE_REJECT:
            begin
                done       = 1'b1;
                engine_rst = 1'b1;
                next_state = IDLE;
            end
            ERROR:
            begin
                // sticky until reset
                error = 1'b1;
            end
        endcase
    end

    // error stays up and no completion is ever reported after it
    a_error_sticky: assert property (@(posedge clk) disable iff (rst)
        error |=> error && !done)
        else $error("done after error");

endmodule

// ==== source/coprocessor_top.sv ====
module coprocessor_top
(
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          valid,
    output logic                          ready,
    input  window_pkg::char_ptr_t         start_ptr,
    input  window_pkg::char_ptr_t         end_ptr,
    output logic                          done,
    output logic                          accept,
    output logic                          error,
    output logic                          mem_valid,
    input  logic                          mem_ready,
    output window_pkg::mem_addr_t         mem_addr,
    input  window_pkg::mem_word_t         mem_data,
    output window_pkg::window_t           window,
    output window_pkg::slot_flags_t       window_enable,
    output window_pkg::slot_flags_t       window_end_of_s,
    output logic                          new_char,
    output logic                          engine_start,
    output logic                          engine_rst,
    input  logic                          engine_start_ready,
    input  supervisor_pkg::engine_flags_t any_accept,
    input  supervisor_pkg::engine_flags_t any_running,
    input  supervisor_pkg::engine_flags_t all_full,
    input  window_pkg::slot_flags_t       elaborating_chars
);
    import window_pkg::*;

    // command strobes from the supervisor
    logic capture_start;
    logic load_first;
    logic shift;
    logic fill_from_mem;
    logic fill_from_buffer;
    logic sel_start_addr;
    // pointer conditions from the character buffer
    logic      start_misaligned;
    logic      fetch_from_mem_due;
    logic      at_end_ptr;
    logic      end_in_first_window;
    slot_idx_t cur_slot;
    slot_idx_t end_slot;
    // window state seen by the supervisor
    logic first_executing;
    logic first_is_end;
    logic fill;
    logic no_work;

    assign fill    = fill_from_mem | fill_from_buffer;
    // no engine holds work on any slot
    assign no_work = ~|elaborating_chars;

    char_buffer u_char_buffer (
        .clk                 (clk),
        .rst                 (rst),
        .start_ptr           (start_ptr),
        .end_ptr             (end_ptr),
        .mem_data            (mem_data),
        .capture_start       (capture_start),
        .load_first          (load_first),
        .shift               (shift),
        .fill_from_mem       (fill_from_mem),
        .fill_from_buffer    (fill_from_buffer),
        .sel_start_addr      (sel_start_addr),
        .mem_addr            (mem_addr),
        .window              (window),
        .start_misaligned    (start_misaligned),
        .fetch_from_mem_due  (fetch_from_mem_due),
        .at_end_ptr          (at_end_ptr),
        .end_in_first_window (end_in_first_window),
        .cur_slot            (cur_slot),
        .end_slot            (end_slot)
    );

    window_flags u_window_flags (
        .clk                 (clk),
        .rst                 (rst),
        .load_first          (load_first),
        .shift               (shift),
        .fill                (fill),
        .end_in_first_window (end_in_first_window),
        .at_end_ptr          (at_end_ptr),
        .cur_slot            (cur_slot),
        .end_slot            (end_slot),
        .elaborating_chars   (elaborating_chars),
        .window_enable       (window_enable),
        .window_end_of_s     (window_end_of_s),
        .first_executing     (first_executing),
        .first_is_end        (first_is_end)
    );

    supervisor_fsm u_supervisor_fsm (
        .clk                 (clk),
        .rst                 (rst),
        .valid               (valid),
        .mem_ready           (mem_ready),
        .engine_start_ready  (engine_start_ready),
        .any_accept          (any_accept),
        .any_running         (any_running),
        .all_full            (all_full),
        .start_misaligned    (start_misaligned),
        .fetch_from_mem_due  (fetch_from_mem_due),
        .first_executing     (first_executing),
        .first_is_end        (first_is_end),
        .no_work             (no_work),
        .ready               (ready),
        .done                (done),
        .accept              (accept),
        .error               (error),
        .mem_valid           (mem_valid),
        .new_char            (new_char),
        .engine_start        (engine_start),
        .engine_rst          (engine_rst),
        .capture_start       (capture_start),
        .load_first          (load_first),
        .shift               (shift),
        .fill_from_mem       (fill_from_mem),
        .fill_from_buffer    (fill_from_buffer),
        .sel_start_addr      (sel_start_addr)
    );

endmodule

// ==== tb/tb_coprocessor.sv ====
`include "coprocessor_cfg.svh"

module tb_coprocessor;
    import window_pkg::*;

    logic                          clk;
    logic                          rst;
    logic                          valid;
    logic                          ready;
    char_ptr_t                     start_ptr;
    char_ptr_t                     end_ptr;
    logic                          done;
    logic                          accept;
    logic                          error;
    logic                          mem_valid;
    logic                          mem_ready;
    mem_addr_t                     mem_addr;
    mem_word_t                     mem_data;
    window_t                       window;
    slot_flags_t                   window_enable;
    slot_flags_t                   window_end_of_s;
    logic                          new_char;
    logic                          engine_start;
    logic                          engine_rst;
    logic                          engine_start_ready;
    supervisor_pkg::engine_flags_t any_accept;
    supervisor_pkg::engine_flags_t any_running;
    supervisor_pkg::engine_flags_t all_full;
    slot_flags_t                   elaborating_chars;

    // string memory image
    mem_word_t mem [0:(1<<`MEM_ADDR_W)-1];

    // test lines from the golden file
    int          q_start[$];
    int          q_end[$];
    int          q_accept[$];
    int          q_full[$];
    int          q_stall[$];
    logic [63:0] q_kind[$];

    integer seed;
    int     limit_cycles;

    // host and reset values applied at the next falling edge
    logic      rst_drv;
    logic      valid_drv;
    char_ptr_t start_drv;
    char_ptr_t end_drv;

    // engine and memory model state
    int        stall_cur;
    int        full_cur;
    int        accept_cur;
    bit        running;
    int        nc_count;
    char_ptr_t fetch_ptr;
    int        pend_cnt;
    char_ptr_t pend_ptr;
    bit        first_due;
    bit        start_next;
    bit        req_open;
    int        stall_left;
    bit        grant_prev;
    mem_addr_t grant_addr;
    logic      s_done;
    logic      s_error;

    coprocessor_top u_coprocessor_top (.*);

    always #20 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_outcome(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("** Error at time %0t: %s is %b, expected %b",
                                $time, name, got, exp));
    endtask

    task automatic check_char(input string name, input char_t got, input char_t exp);
        if (got !== exp)
            abort_run($sformatf("** Error at time %0t: %s is %h, expected %h",
                                $time, name, got, exp));
    endtask

    task automatic check_flags(input string name, input slot_flags_t got,
                               input slot_flags_t exp);
        if (got !== exp)
            abort_run($sformatf("** Error at time %0t: %s is %b, expected %b",
                                $time, name, got, exp));
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp)
            abort_run($sformatf("** Error at time %0t: %s is %0d, expected %0d",
                                $time, name, got, exp));
    endtask

    // character at a pointer, low byte of a word is character 0
    function automatic char_t mem_char(input char_ptr_t p);
        mem_word_t w;
        w = mem[p[`PTR_W-1:`CHAR_ADDR_OFFSET]];
        return w[p[`CHAR_ADDR_OFFSET-1:0]*`CHAR_W +: `CHAR_W];
    endfunction

    // one clock cycle that drives at the falling edge, settles and then samples
    task automatic tick();
        int slot;
        @(negedge clk);
        rst       = rst_drv;
        valid     = valid_drv;
        start_ptr = start_drv;
        end_ptr   = end_drv;
        // memory answers one cycle after the grant
        if (grant_prev)
            mem_data = mem[grant_addr];
        // engine model where the oldest slot finishes at once
        any_accept = running && accept_cur >= 0 && nc_count >= accept_cur;
        all_full   = running && full_cur != 0;
        elaborating_chars = running ?
            (window_enable & ~(slot_flags_t'(1) << (nc_count % `WINDOW_CHARS))) : '0;
        #1;
        // new requests stall at random
        if (!mem_valid || rst_drv)
        begin
            req_open   = 0;
            stall_left = 0;
            mem_ready  = 1'b0;
        end
        else
        begin
            if (!req_open)
            begin
                req_open   = 1;
                stall_left = (($random(seed) & 1) != 0) ? stall_cur : 0;
            end
            if (stall_left > 0)
            begin
                mem_ready  = 1'b0;
                stall_left = stall_left - 1;
            end
            else
                mem_ready = 1'b1;
        end
        #1;
        grant_prev = !rst_drv && mem_valid && mem_ready;
        grant_addr = mem_addr;
        if (grant_prev)
            req_open = 0;
        s_done  = done;
        s_error = error;
        // engines start in the cycle right after an aligned start is taken
        if (start_next)
        begin
            start_next = 0;
            check_outcome("engine_start", engine_start, start_drv[`CC_ID_BITS-1:0] == '0);
        end
        // first window holds the four characters from start_ptr
        if (first_due)
        begin
            first_due = 0;
            for (slot = 0; slot < `WINDOW_CHARS; slot++)
                check_char($sformatf("window slot %0d", slot), window[slot*`CHAR_W +: `CHAR_W],
                           mem_char(start_drv + char_ptr_t'(slot)));
        end
        // the slot filled after a new_char holds the fetched character
        if (pend_cnt > 0)
        begin
            pend_cnt = pend_cnt - 1;
            if (pend_cnt == 0)
            begin
                slot = int'(pend_ptr[`CC_ID_BITS-1:0]);
                check_char($sformatf("window slot %0d", slot), window[slot*`CHAR_W +: `CHAR_W],
                           mem_char(pend_ptr));
            end
        end
        if (running && engine_start)
            first_due = 1;
        if (running && new_char)
        begin
            pend_cnt  = 2;
            pend_ptr  = fetch_ptr;
            fetch_ptr = fetch_ptr + 1'b1;
            nc_count  = nc_count + 1;
        end
        // start taken by the controller
        if (valid_drv && ready && !rst_drv)
        begin
            running    = 1;
            valid_drv  = 1'b0;
            start_next = 1;
        end
    endtask

    task automatic apply_reset();
        rst_drv    = 1'b1;
        valid_drv  = 1'b0;
        running    = 0;
        pend_cnt   = 0;
        first_due  = 0;
        start_next = 0;
        repeat (8) tick();
        rst_drv = 1'b0;
        tick();
        check_outcome("done", done, 1'b0);
        check_outcome("accept", accept, 1'b0);
        check_outcome("error", error, 1'b0);
        check_outcome("new_char", new_char, 1'b0);
        check_outcome("engine_start", engine_start, 1'b0);
        check_flags("window_enable", window_enable, '0);
        check_outcome("mem_valid", mem_valid, 1'b1);
        check_outcome("ready", ready, mem_ready);
    endtask

    task automatic load_golden();
        integer      fd;
        string       line;
        int          n;
        int          idx;
        mem_word_t   word;
        int          a;
        int          b;
        int          c;
        int          d;
        int          e;
        logic [63:0] kind;
        // untouched words carry their own address
        for (int i = 0; i < (1 << `MEM_ADDR_W); i++)
            mem[i] = {32'hc0de_5a5a, 19'd0, mem_addr_t'(i)};
        fd = $fopen("tb/golden_vectors.txt", "r");
        if (fd == 0)
            abort_run("cannot open tb/golden_vectors.txt");
        limit_cycles = 0;
        while (!$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.len() > 0 && line[0] != "#")
            begin
                if ($sscanf(line, "m %d %h", idx, word) == 2)
                    mem[idx] = word;
                else if ($sscanf(line, "t %d %d %d %d %d %s", a, b, c, d, e, kind) == 6)
                begin
                    q_start.push_back(a);
                    q_end.push_back(b);
                    q_accept.push_back(c);
                    q_full.push_back(d);
                    q_stall.push_back(e);
                    q_kind.push_back(kind);
                    // each word request can stall
                    limit_cycles = limit_cycles + 200 + e * 16;
                end
            end
        end
        $fclose(fd);
        if (q_start.size() == 0)
            abort_run("golden file holds no test lines");
        limit_cycles = limit_cycles + 50;
    endtask

    task automatic run_one(input int i);
        char_ptr_t   sp;
        int          k;
        int          len;
        int          exp_count;
        logic [63:0] kind_rule;
        logic        exp_error;
        logic        exp_accept;
        slot_flags_t exp_eos;
        sp  = char_ptr_t'(q_start[i]);
        k   = q_accept[i];
        len = q_end[i] - q_start[i];
        // misaligned start and full engines end in error
        // accept at k unless the end comes first
        if (sp[`CC_ID_BITS-1:0] != '0 || q_full[i] != 0)
            kind_rule = "error";
        else if (k >= 0 && k <= len)
            kind_rule = "accept";
        else
            kind_rule = "reject";
        if (kind_rule != q_kind[i])
            abort_run($sformatf("golden outcome of test %0d does not follow from its stimulus", i));
        exp_error  = kind_rule == "error";
        exp_accept = kind_rule == "accept";
        exp_count  = exp_error ? 0 : (exp_accept ? k : len);
        // terminator is flagged in its slot once it has entered the window
        exp_eos    = '0;
        if (len <= exp_count + `WINDOW_CHARS - 1)
            exp_eos = slot_flags_t'(1) << (q_end[i] % `WINDOW_CHARS);

        start_drv  = sp;
        end_drv    = char_ptr_t'(q_end[i]);
        valid_drv  = 1'b1;
        stall_cur  = q_stall[i];
        full_cur   = q_full[i];
        accept_cur = k;
        nc_count   = 0;
        // first advance fetches the character after the first window
        fetch_ptr  = sp + char_ptr_t'(`WINDOW_CHARS);
        do
            tick();
        while (!(s_done === 1'b1 || s_error === 1'b1));
        running = 0;

        check_outcome("error", s_error, exp_error);
        check_outcome("done", s_done, !exp_error);
        check_outcome("accept", accept, exp_accept);
        // the first slot reaches the terminator after end_ptr - start_ptr advances
        check_count("new_char count", nc_count, exp_count);

        if (exp_error)
        begin
            // error is held with no completion
            repeat (4)
            begin
                tick();
                check_outcome("error", error, 1'b1);
                check_outcome("done", done, 1'b0);
            end
            apply_reset();
        end
        else
        begin
            // engines are reset together with done
            check_outcome("engine_rst", engine_rst, 1'b1);
            check_flags("window_end_of_s", window_end_of_s, exp_eos);
            // done is a single pulse
            repeat (3)
            begin
                tick();
                check_outcome("done", done, 1'b0);
                check_outcome("new_char", new_char, 1'b0);
            end
        end
    endtask

    // ends a run that stops making progress
    initial
    begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        abort_run($sformatf("timeout, no end of run after %0d cycles", limit_cycles));
    end

    initial
    begin
        clk                = 1'b0;
        rst                = 1'b1;
        valid              = 1'b0;
        start_ptr          = '0;
        end_ptr            = '0;
        mem_ready          = 1'b0;
        mem_data           = '0;
        engine_start_ready = 1'b1;
        any_accept         = 1'b0;
        any_running        = 1'b1;
        all_full           = 1'b0;
        elaborating_chars  = '0;
        seed               = 32'hfae7_5a2d;
        rst_drv            = 1'b1;
        valid_drv          = 1'b0;
        start_drv          = '0;
        end_drv            = '0;
        stall_cur          = 0;
        full_cur           = 0;
        accept_cur         = -1;
        running            = 0;
        nc_count           = 0;
        fetch_ptr          = '0;
        pend_cnt           = 0;
        pend_ptr           = '0;
        first_due          = 0;
        start_next         = 0;
        req_open           = 0;
        stall_left         = 0;
        grant_prev         = 0;
        grant_addr         = '0;
        s_done             = 1'b0;
        s_error            = 1'b0;
        limit_cycles       = 0;

        load_golden();
        apply_reset();
        foreach (q_start[i])
            run_one(i);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+source
source/window_pkg.sv
source/supervisor_pkg.sv
source/char_buffer.sv
source/window_flags.sv
source/supervisor_fsm.sv
source/coprocessor_top.sv
tb/tb_coprocessor.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line in the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_coprocessor \
    -f flist.f \
    -o sim_coprocessor

./obj_dir/sim_coprocessor > sim.log 2>&1 || true
cat sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== tb/golden_vectors.txt ====
# m <word index> <64-bit memory word in hex, character 0 in the low byte>
# t <start_ptr> <end_ptr> <accept_after, -1 for none> <force_full> <stall_cycles> <outcome>
m 0 4746454443424140
m 1 4f4e4d4c4b4a4948
m 2 5756555453525150
m 3 5f5e5d5c5b5a5958
m 4 6766656463626160
m 5 6f6e6d6c6b6a6968
m 6 7776757473727170
m 7 7f7e7d7c7b7a7978
t 0 9 -1 0 0 reject
t 4 21 -1 0 2 reject
t 8 30 5 0 0 accept
t 12 13 -1 0 0 reject
t 16 16 -1 0 3 reject
t 6 20 -1 0 0 error
t 20 40 -1 1 0 error
t 24 50 12 0 4 accept
t 32 55 -1 0 1 reject
t 0 60 0 0 0 accept
